//--- apb_iob_pkg.sv
package apb_iob_pkg;

   // Bus widths
   localparam int ADDR_W = 12;           // Byte address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;   // One strobe per byte

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;

   // Address map, decoded on bits 11:10
   // Regions 2 and 3 are unmapped and answered with an error
   localparam logic [1:0] REGION_REGBANK = 2'd0;
   localparam logic [1:0] REGION_SRAM    = 2'd1;

   // Word indexes inside each region
   typedef logic [3:0] reg_idx_t;    // Address bits 5:2
   typedef logic [7:0] sram_idx_t;   // Address bits 9:2

   // Idle cycles of avalid before the SRAM accepts
   localparam int SRAM_WAIT = 2;

   // Bridge transfer states
   typedef enum logic [1:0] {
      BR_IDLE,     // Waiting for psel
      BR_ACCESS,   // IOb request in flight
      BR_DONE      // Ready given, waiting for psel to drop
   } bridge_state_e;

endpackage

//--- apb2iob.sv
module apb2iob (
   input  logic                clk_i,
   input  logic                rst_n_i,

   // APB slave side
   input  logic                apb_sel_i,
   input  logic                apb_enable_i,
   input  logic                apb_write_i,
   input  apb_iob_pkg::addr_t  apb_addr_i,
   input  apb_iob_pkg::data_t  apb_wdata_i,
   input  apb_iob_pkg::strb_t  apb_wstrb_i,
   output logic                apb_ready_o,
   output logic                apb_slverr_o,
   output apb_iob_pkg::data_t  apb_rdata_o,

   // IOb master side
   output logic                iob_avalid_o,
   output apb_iob_pkg::addr_t  iob_addr_o,
   output apb_iob_pkg::data_t  iob_wdata_o,
   output apb_iob_pkg::strb_t  iob_wstrb_o,
   input  logic                iob_ready_nxt_i,
   input  logic                iob_rvalid_nxt_i,
   input  logic                iob_err_nxt_i,
   input  apb_iob_pkg::data_t  iob_rdata_i
);

   apb_iob_pkg::bridge_state_e state_q, state_d;

   logic avalid_d;
   logic done;      // Transfer ends this cycle
   logic err_set;   // Error seen this cycle
   logic err_q, err_d;

   always_comb begin
      state_d  = state_q;
      avalid_d = iob_avalid_o;
      err_d    = err_q;
      done     = 1'b0;
      err_set  = 1'b0;

      case (state_q)
         apb_iob_pkg::BR_IDLE: begin
            if (apb_sel_i) begin
               state_d  = apb_iob_pkg::BR_ACCESS;
               avalid_d = 1'b1;
               err_d    = 1'b0;   // New transfer starts clean
            end
         end

         apb_iob_pkg::BR_ACCESS: begin
            // Enable must be high for the whole access phase
            err_set = ~apb_enable_i | iob_err_nxt_i;
            err_d   = err_q | err_set;

            if (iob_avalid_o && iob_ready_nxt_i)
               avalid_d = 1'b0;   // Accepted, drop valid next cycle

            // Reads also wait for the data
            if (apb_write_i)
               done = iob_avalid_o & iob_ready_nxt_i;
            else
               done = iob_rvalid_nxt_i;

            if (done)
               state_d = apb_iob_pkg::BR_DONE;
         end

         apb_iob_pkg::BR_DONE: begin
            if (!apb_sel_i)
               state_d = apb_iob_pkg::BR_IDLE;
         end

         default: state_d = apb_iob_pkg::BR_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q      <= apb_iob_pkg::BR_IDLE;
         iob_avalid_o <= 1'b0;
         err_q        <= 1'b0;
         apb_ready_o  <= 1'b0;
         apb_slverr_o <= 1'b0;
      end else begin
         state_q      <= state_d;
         iob_avalid_o <= avalid_d;
         err_q        <= err_d;
         apb_ready_o  <= done;                          // One-cycle pulse
         apb_slverr_o <= done & (err_q | err_set);      // Only alongside ready
      end
   end

   // Request fields come straight from APB
   assign iob_addr_o  = apb_addr_i;
   assign iob_wdata_o = apb_wdata_i;
   assign iob_wstrb_o = apb_write_i ? apb_wstrb_i : '0;   // Zero strobe marks a read

   // Slave holds read data until the next request
   assign apb_rdata_o = iob_rdata_i;

   // The master must not raise penable outside a selected transfer
   a_enable_needs_sel: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      apb_enable_i |-> apb_sel_i
   );

   // The IOb request is held until the slave side accepts it
   a_avalid_held: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      iob_avalid_o && !iob_ready_nxt_i |=> iob_avalid_o
   );

   a_ready_pulse: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      apb_ready_o |=> !apb_ready_o
   );

endmodule

//--- iob_split.sv
module iob_split (
   input  logic                clk_i,
   input  logic                rst_n_i,

   // From the bridge
   input  logic                avalid_i,
   input  apb_iob_pkg::addr_t  addr_i,
   input  apb_iob_pkg::data_t  wdata_i,
   input  apb_iob_pkg::strb_t  wstrb_i,
   output logic                ready_nxt_o,
   output logic                rvalid_nxt_o,
   output logic                err_nxt_o,
   output apb_iob_pkg::data_t  rdata_o,

   // Register bank
   output logic                rb_avalid_o,
   output apb_iob_pkg::addr_t  rb_addr_o,
   output apb_iob_pkg::data_t  rb_wdata_o,
   output apb_iob_pkg::strb_t  rb_wstrb_o,
   input  logic                rb_ready_nxt_i,
   input  logic                rb_rvalid_nxt_i,
   input  apb_iob_pkg::data_t  rb_rdata_i,

   // SRAM
   output logic                sr_avalid_o,
   output apb_iob_pkg::addr_t  sr_addr_o,
   output apb_iob_pkg::data_t  sr_wdata_o,
   output apb_iob_pkg::strb_t  sr_wstrb_o,
   input  logic                sr_ready_nxt_i,
   input  logic                sr_rvalid_nxt_i,
   input  apb_iob_pkg::data_t  sr_rdata_i
);

   logic [1:0] region;
   logic       sel_rb, sel_sr, unmapped;
   logic [1:0] rsel_q;   // Region of the last accepted request

   assign region   = addr_i[apb_iob_pkg::ADDR_W-1 -: 2];
   assign sel_rb   = (region == apb_iob_pkg::REGION_REGBANK);
   assign sel_sr   = (region == apb_iob_pkg::REGION_SRAM);
   assign unmapped = ~sel_rb & ~sel_sr;

   // Only the addressed slave sees the valid
   assign rb_avalid_o = avalid_i & sel_rb;
   assign sr_avalid_o = avalid_i & sel_sr;

   assign rb_addr_o  = addr_i;
   assign rb_wdata_o = wdata_i;
   assign rb_wstrb_o = wstrb_i;
   assign sr_addr_o  = addr_i;
   assign sr_wdata_o = wdata_i;
   assign sr_wstrb_o = wstrb_i;

   // Unmapped requests are answered here at once
   always_comb begin
      if (sel_rb) begin
         ready_nxt_o  = rb_ready_nxt_i;
         rvalid_nxt_o = rb_rvalid_nxt_i;
      end else if (sel_sr) begin
         ready_nxt_o  = sr_ready_nxt_i;
         rvalid_nxt_o = sr_rvalid_nxt_i;
      end else begin
         ready_nxt_o  = avalid_i;
         rvalid_nxt_o = avalid_i & ~|wstrb_i;
      end
   end

   assign err_nxt_o = avalid_i & unmapped;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         rsel_q <= 2'b11;   // Unmapped, reads zero
      else if (avalid_i && ready_nxt_o)
         rsel_q <= region;
   end

   always_comb begin
      case (rsel_q)
         apb_iob_pkg::REGION_REGBANK: rdata_o = rb_rdata_i;
         apb_iob_pkg::REGION_SRAM:    rdata_o = sr_rdata_i;
         default:                     rdata_o = '0;
      endcase
   end

   a_one_slave: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(rb_avalid_o && sr_avalid_o)
   );

endmodule

//--- iob_regbank.sv
module iob_regbank (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                avalid_i,
   input  apb_iob_pkg::addr_t  addr_i,
   input  apb_iob_pkg::data_t  wdata_i,
   input  apb_iob_pkg::strb_t  wstrb_i,
   output logic                ready_nxt_o,
   output logic                rvalid_nxt_o,
   output apb_iob_pkg::data_t  rdata_o
);

   apb_iob_pkg::data_t    regs_q [2**$bits(apb_iob_pkg::reg_idx_t)];
   apb_iob_pkg::reg_idx_t idx;
   logic                  wr_en;

   // Word index, byte offset dropped
   assign idx = addr_i[2 +: $bits(apb_iob_pkg::reg_idx_t)];

   // Always ready
   assign ready_nxt_o  = avalid_i;
   assign rvalid_nxt_o = avalid_i & ~|wstrb_i;   // Empty strobe is a read
   assign wr_en        = avalid_i & |wstrb_i;

   // Byte-strobed register writes
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 2**$bits(apb_iob_pkg::reg_idx_t); i++)
            regs_q[i] <= '0;
      end else if (wr_en) begin
         for (int b = 0; b < apb_iob_pkg::STRB_W; b++) begin
            if (wstrb_i[b])
               regs_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
         end
      end
   end

   // Read data shows up the cycle after rvalid_nxt and stays put
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         rdata_o <= '0;
      else if (rvalid_nxt_o)
         rdata_o <= regs_q[idx];
   end

endmodule

//--- iob_sram.sv
module iob_sram (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                avalid_i,
   input  apb_iob_pkg::addr_t  addr_i,
   input  apb_iob_pkg::data_t  wdata_i,
   input  apb_iob_pkg::strb_t  wstrb_i,
   output logic                ready_nxt_o,
   output logic                rvalid_nxt_o,
   output apb_iob_pkg::data_t  rdata_o
);

   apb_iob_pkg::data_t     mem [2**$bits(apb_iob_pkg::sram_idx_t)];
   apb_iob_pkg::sram_idx_t idx;

   logic [$clog2(apb_iob_pkg::SRAM_WAIT+1)-1:0] cnt_q;   // Wait cycles seen
   logic                                        accept;

   assign idx = addr_i[2 +: $bits(apb_iob_pkg::sram_idx_t)];

   // Accept once the wait count is used up
   assign accept       = avalid_i && (cnt_q == apb_iob_pkg::SRAM_WAIT);
   assign ready_nxt_o  = accept;
   assign rvalid_nxt_o = accept & ~|wstrb_i;

   // Counts cycles of a pending request, back to zero on accept
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         cnt_q <= '0;
      else if (!avalid_i || accept)
         cnt_q <= '0;
      else
         cnt_q <= cnt_q + 1'b1;
   end

   // Memory array and registered read port
   always_ff @(posedge clk_i) begin
      if (accept) begin
         if (|wstrb_i) begin
            for (int b = 0; b < apb_iob_pkg::STRB_W; b++) begin
               if (wstrb_i[b])
                  mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end else begin
            rdata_o <= mem[idx];   // Held until the next read
         end
      end
   end

   a_cnt_bound: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      cnt_q <= apb_iob_pkg::SRAM_WAIT
   );

endmodule

//--- apb_iob_sys.sv
module apb_iob_sys (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                apb_sel_i,
   input  logic                apb_enable_i,
   input  logic                apb_write_i,
   input  apb_iob_pkg::addr_t  apb_addr_i,
   input  apb_iob_pkg::data_t  apb_wdata_i,
   input  apb_iob_pkg::strb_t  apb_wstrb_i,
   output logic                apb_ready_o,
   output logic                apb_slverr_o,
   output apb_iob_pkg::data_t  apb_rdata_o
);

   // Bridge to splitter
   logic               iob_avalid;
   apb_iob_pkg::addr_t iob_addr;
   apb_iob_pkg::data_t iob_wdata;
   apb_iob_pkg::strb_t iob_wstrb;
   logic               iob_ready_nxt;
   logic               iob_rvalid_nxt;
   logic               iob_err_nxt;
   apb_iob_pkg::data_t iob_rdata;

   // Splitter to register bank
   logic               rb_avalid;
   apb_iob_pkg::addr_t rb_addr;
   apb_iob_pkg::data_t rb_wdata;
   apb_iob_pkg::strb_t rb_wstrb;
   logic               rb_ready_nxt;
   logic               rb_rvalid_nxt;
   apb_iob_pkg::data_t rb_rdata;

   // Splitter to SRAM
   logic               sr_avalid;
   apb_iob_pkg::addr_t sr_addr;
   apb_iob_pkg::data_t sr_wdata;
   apb_iob_pkg::strb_t sr_wstrb;
   logic               sr_ready_nxt;
   logic               sr_rvalid_nxt;
   apb_iob_pkg::data_t sr_rdata;

   apb2iob u_bridge (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .apb_sel_i        (apb_sel_i),
      .apb_enable_i     (apb_enable_i),
      .apb_write_i      (apb_write_i),
      .apb_addr_i       (apb_addr_i),
      .apb_wdata_i      (apb_wdata_i),
      .apb_wstrb_i      (apb_wstrb_i),
      .apb_ready_o      (apb_ready_o),
      .apb_slverr_o     (apb_slverr_o),
      .apb_rdata_o      (apb_rdata_o),
      .iob_avalid_o     (iob_avalid),
      .iob_addr_o       (iob_addr),
      .iob_wdata_o      (iob_wdata),
      .iob_wstrb_o      (iob_wstrb),
      .iob_ready_nxt_i  (iob_ready_nxt),
      .iob_rvalid_nxt_i (iob_rvalid_nxt),
      .iob_err_nxt_i    (iob_err_nxt),
      .iob_rdata_i      (iob_rdata)
   );

   iob_split u_split (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .avalid_i        (iob_avalid),
      .addr_i          (iob_addr),
      .wdata_i         (iob_wdata),
      .wstrb_i         (iob_wstrb),
      .ready_nxt_o     (iob_ready_nxt),
      .rvalid_nxt_o    (iob_rvalid_nxt),
      .err_nxt_o       (iob_err_nxt),
      .rdata_o         (iob_rdata),
      .rb_avalid_o     (rb_avalid),
      .rb_addr_o       (rb_addr),
      .rb_wdata_o      (rb_wdata),
      .rb_wstrb_o      (rb_wstrb),
      .rb_ready_nxt_i  (rb_ready_nxt),
      .rb_rvalid_nxt_i (rb_rvalid_nxt),
      .rb_rdata_i      (rb_rdata),
      .sr_avalid_o     (sr_avalid),
      .sr_addr_o       (sr_addr),
      .sr_wdata_o      (sr_wdata),
      .sr_wstrb_o      (sr_wstrb),
      .sr_ready_nxt_i  (sr_ready_nxt),
      .sr_rvalid_nxt_i (sr_rvalid_nxt),
      .sr_rdata_i      (sr_rdata)
   );

   iob_regbank u_regbank (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .avalid_i     (rb_avalid),
      .addr_i       (rb_addr),
      .wdata_i      (rb_wdata),
      .wstrb_i      (rb_wstrb),
      .ready_nxt_o  (rb_ready_nxt),
      .rvalid_nxt_o (rb_rvalid_nxt),
      .rdata_o      (rb_rdata)
   );

   iob_sram u_sram (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .avalid_i     (sr_avalid),
      .addr_i       (sr_addr),
      .wdata_i      (sr_wdata),
      .wstrb_i      (sr_wstrb),
      .ready_nxt_o  (sr_ready_nxt),
      .rvalid_nxt_o (sr_rvalid_nxt),
      .rdata_o      (sr_rdata)
   );

endmodule

//--- apb_iob_tb.sv
module apb_iob_tb;

   localparam int CLK_PERIOD  = 40;
   localparam int RST_CYCLES  = 8;
   localparam int NUM_RAND    = 40;
   localparam int READY_LIMIT = 4 * (apb_iob_pkg::SRAM_WAIT + 6);   // Cycles to wait for ready

   typedef struct packed {
      logic               wr;
      logic               late;        // Enable held low one extra cycle
      apb_iob_pkg::addr_t addr;
      apb_iob_pkg::data_t wdata;
      apb_iob_pkg::strb_t strb;
      apb_iob_pkg::data_t exp_rdata;   // Reads only
      logic               exp_err;
   } vec_t;

   // Directed transfers
   localparam int NUM_VEC = 17;
   localparam vec_t VECS [NUM_VEC] = '{
      '{1'b1, 1'b0, 12'h00C, 32'hDEADBEEF, 4'hF, 32'h0000_0000, 1'b0},   // Register full word
      '{1'b0, 1'b0, 12'h00C, 32'h0000_0000, 4'h0, 32'hDEADBEEF, 1'b0},
      '{1'b1, 1'b0, 12'h014, 32'h11223344, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b1, 1'b0, 12'h014, 32'hAABBCCDD, 4'h5, 32'h0000_0000, 1'b0},   // Bytes 0 and 2
      '{1'b0, 1'b0, 12'h014, 32'h0000_0000, 4'h0, 32'h11BB33DD, 1'b0},
      '{1'b0, 1'b0, 12'h000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0},   // Reset value
      '{1'b1, 1'b0, 12'h404, 32'hCAFEF00D, 4'hF, 32'h0000_0000, 1'b0},   // SRAM
      '{1'b0, 1'b0, 12'h404, 32'h0000_0000, 4'h0, 32'hCAFEF00D, 1'b0},
      '{1'b1, 1'b0, 12'h7FC, 32'h01234567, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b1, 1'b0, 12'h7FC, 32'hFFFFFFFF, 4'h8, 32'h0000_0000, 1'b0},
      '{1'b0, 1'b0, 12'h7FC, 32'h0000_0000, 4'h0, 32'hFF234567, 1'b0},
      '{1'b0, 1'b0, 12'h800, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1},   // Unmapped
      '{1'b1, 1'b0, 12'hC10, 32'h5555AAAA, 4'hF, 32'h0000_0000, 1'b1},
      '{1'b0, 1'b0, 12'hFFC, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1},
      '{1'b0, 1'b1, 12'h00C, 32'h0000_0000, 4'h0, 32'hDEADBEEF, 1'b1},   // Late enable
      '{1'b0, 1'b1, 12'h404, 32'h0000_0000, 4'h0, 32'hCAFEF00D, 1'b1},
      '{1'b0, 1'b0, 12'h00C, 32'h0000_0000, 4'h0, 32'hDEADBEEF, 1'b0}    // Error cleared again
   };

   localparam int WATCHDOG_T =
      (NUM_VEC + NUM_RAND) * (apb_iob_pkg::SRAM_WAIT + 6) * CLK_PERIOD;

   logic               clk;
   logic               rst_n;
   logic               apb_sel;
   logic               apb_enable;
   logic               apb_write;
   apb_iob_pkg::addr_t apb_addr;
   apb_iob_pkg::data_t apb_wdata;
   apb_iob_pkg::strb_t apb_wstrb;
   logic               apb_ready;
   logic               apb_slverr;
   apb_iob_pkg::data_t apb_rdata;

   // Shadow model of both slaves
   apb_iob_pkg::data_t rb_model [2**$bits(apb_iob_pkg::reg_idx_t)];
   apb_iob_pkg::data_t sr_model [2**$bits(apb_iob_pkg::sram_idx_t)];
   logic               sr_known [2**$bits(apb_iob_pkg::sram_idx_t)];   // SRAM is not reset

   logic [31:0] rng_state = 32'd28;

   apb_iob_sys DUT (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .apb_sel_i    (apb_sel),
      .apb_enable_i (apb_enable),
      .apb_write_i  (apb_write),
      .apb_addr_i   (apb_addr),
      .apb_wdata_i  (apb_wdata),
      .apb_wstrb_i  (apb_wstrb),
      .apb_ready_o  (apb_ready),
      .apb_slverr_o (apb_slverr),
      .apb_rdata_o  (apb_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_data(input string name, input apb_iob_pkg::data_t exp,
                             input apb_iob_pkg::data_t act);
      if (act !== exp)
         stop_on_error($sformatf("FAIL t=%0t %s expected 0x%08h got 0x%08h",
                                 $time, name, exp, act));
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_on_error($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, act));
   endtask

   task automatic check_ready(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_on_error($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, act));
   endtask

   // LCG with the usual 32-bit constants
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Strobed bytes take the new data, the rest keep the old word
   function automatic apb_iob_pkg::data_t merge_bytes(input apb_iob_pkg::data_t old_w,
                                                      input apb_iob_pkg::data_t new_w,
                                                      input apb_iob_pkg::strb_t strb);
      apb_iob_pkg::data_t res;
      res = old_w;
      for (int b = 0; b < apb_iob_pkg::STRB_W; b++)
         if (strb[b])
            res[b*8 +: 8] = new_w[b*8 +: 8];
      return res;
   endfunction

   task automatic model_write(input apb_iob_pkg::addr_t addr, input apb_iob_pkg::data_t wdata,
                              input apb_iob_pkg::strb_t strb);
      apb_iob_pkg::reg_idx_t  ri;
      apb_iob_pkg::sram_idx_t si;
      ri = addr[5:2];
      si = addr[9:2];
      if (addr[11:10] == apb_iob_pkg::REGION_REGBANK) begin
         rb_model[ri] = merge_bytes(rb_model[ri], wdata, strb);
      end else if (addr[11:10] == apb_iob_pkg::REGION_SRAM) begin
         sr_model[si] = merge_bytes(sr_model[si], wdata, strb);
         if (strb == 4'hF)
            sr_known[si] = 1'b1;
      end
   endtask

   function automatic apb_iob_pkg::data_t model_read(input apb_iob_pkg::addr_t addr);
      if (addr[11:10] == apb_iob_pkg::REGION_REGBANK)
         return rb_model[addr[5:2]];
      else if (addr[11:10] == apb_iob_pkg::REGION_SRAM)
         return sr_model[addr[9:2]];
      return '0;   // Unmapped reads zero
   endfunction

   // One APB transfer, setup then access until ready
   task automatic apb_transfer(input logic wr, input logic late, input apb_iob_pkg::addr_t addr,
                               input apb_iob_pkg::data_t wdata, input apb_iob_pkg::strb_t strb,
                               output apb_iob_pkg::data_t rdata, output logic err);
      int n;
      @(posedge clk);
      apb_sel    <= 1'b1;
      apb_enable <= 1'b0;
      apb_write  <= wr;
      apb_addr   <= addr;
      apb_wdata  <= wdata;
      apb_wstrb  <= wr ? strb : 4'h0;
      @(posedge clk);
      if (late)
         @(posedge clk);   // Access phase starts one cycle late
      apb_enable <= 1'b1;
      n = 0;
      @(negedge clk);
      while (apb_ready !== 1'b1) begin
         n++;
         if (n > READY_LIMIT)
            stop_on_error($sformatf("No apb_ready_o within %0d cycles for address 0x%03h",
                                    READY_LIMIT, addr));
         @(negedge clk);
      end
      rdata = apb_rdata;
      err   = apb_slverr;
      @(posedge clk);
      apb_sel    <= 1'b0;
      apb_enable <= 1'b0;
      @(negedge clk);
      check_ready("apb_ready_o", 1'b0, apb_ready);   // Ready is a single pulse
      check_err("apb_slverr_o", 1'b0, apb_slverr);
   endtask

   initial begin
      apb_iob_pkg::bridge_state_e st;
      #(WATCHDOG_T);
      st = DUT.u_bridge.state_q;
      stop_on_error($sformatf("Timeout after %0d time units with the bridge in %s",
                              WATCHDOG_T, st.name()));
   end

   initial begin
      apb_iob_pkg::data_t     rdata;
      apb_iob_pkg::data_t     wdata;
      apb_iob_pkg::addr_t     addr;
      apb_iob_pkg::strb_t     strb;
      apb_iob_pkg::sram_idx_t si;
      logic                   err;
      logic                   wr;
      logic                   unmapped;
      logic [31:0]            r;

      rst_n      = 1'b0;
      apb_sel    = 1'b0;
      apb_enable = 1'b0;
      apb_write  = 1'b0;
      apb_addr   = '0;
      apb_wdata  = '0;
      apb_wstrb  = '0;
      foreach (rb_model[i])
         rb_model[i] = '0;
      foreach (sr_known[i])
         sr_known[i] = 1'b0;

      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_ready("apb_ready_o", 1'b0, apb_ready);

      for (int i = 0; i < NUM_VEC; i++) begin
         apb_transfer(VECS[i].wr, VECS[i].late, VECS[i].addr, VECS[i].wdata, VECS[i].strb,
                      rdata, err);
         check_err("apb_slverr_o", VECS[i].exp_err, err);
         if (!VECS[i].wr)
            check_data("apb_rdata_o", VECS[i].exp_rdata, rdata);
         else if (!VECS[i].exp_err)
            model_write(VECS[i].addr, VECS[i].wdata, VECS[i].strb);
      end

      // Random mixed transfers against the shadow model
      for (int i = 0; i < NUM_RAND; i++) begin
         r        = next_rand();
         wdata    = next_rand();
         wr       = r[27];
         strb     = r[26:23];
         unmapped = 1'b0;
         if (r[31:28] < 4'd2) begin
            unmapped = 1'b1;
            addr     = {1'b1, r[22], r[21:14], 2'b00};
         end else if (r[31:28] < 4'd9) begin
            addr = {apb_iob_pkg::REGION_REGBANK, r[22:19], r[18:15], 2'b00};
         end else begin
            si   = {r[18], 3'b000, r[17:14]};
            addr = {apb_iob_pkg::REGION_SRAM, si, 2'b00};
            if (!sr_known[si]) begin
               wr   = 1'b1;   // Fill the word before it can be read
               strb = 4'hF;
            end
         end
         if (wr && strb == 4'h0)
            strb = 4'hF;
         apb_transfer(wr, 1'b0, addr, wdata, strb, rdata, err);
         check_err("apb_slverr_o", unmapped, err);
         if (!wr)
            check_data("apb_rdata_o", model_read(addr), rdata);
         else if (!unmapped)
            model_write(addr, wdata, strb);
      end

      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- apb_iob_sys.f
apb_iob_pkg.sv
apb2iob.sv
iob_split.sv
iob_regbank.sv
iob_sram.sv
apb_iob_sys.sv
apb_iob_tb.sv

//--- Bender.yml
package:
  name: apb_iob_sys

sources:
  # Package first, then the RTL bottom up
  - apb_iob_pkg.sv
  - apb2iob.sv
  - iob_split.sv
  - iob_regbank.sv
  - iob_sram.sv
  - apb_iob_sys.sv

  - target: test
    files:
      - apb_iob_tb.sv
